// ==== Makefile ====
TOP = controlUnitTb

simulate:
	verilator --binary --assert --timescale 1ns/100ps --top-module $(TOP) -f build.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

.PHONY: simulate clean

// ==== build.f ====
logic/controlPkg.sv
logic/instrDecoder.sv
logic/phaseSequencer.sv
logic/controlWordGen.sv
logic/controlUnit.sv
sim/controlUnit_checker.sv
sim/controlUnitTb.sv

// ==== logic/controlPkg.sv ====
package controlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;
    typedef logic [2:0] stepT;

    // opcodes
    localparam opcodeT OpRType = 6'b000000;
    localparam opcodeT OpAddi  = 6'b001000;
    localparam opcodeT OpLw    = 6'b100011;
    localparam opcodeT OpSw    = 6'b101011;
    localparam opcodeT OpBeq   = 6'b000100;
    localparam opcodeT OpBne   = 6'b000101;
    localparam opcodeT OpJ     = 6'b000010;
    localparam opcodeT OpJal   = 6'b000011;

    // R-type funct codes
    localparam functT FnAdd = 6'b100000;
    localparam functT FnSub = 6'b100010;
    localparam functT FnAnd = 6'b100100;
    localparam functT FnSll = 6'b000000;
    localparam functT FnSrl = 6'b000010;
    localparam functT FnSra = 6'b000011;

    typedef enum logic [3:0] {
        clsAluReg,
        clsShift,
        clsAddi,
        clsLoad,
        clsStore,
        clsBranchEq,
        clsBranchNe,
        clsJump,
        clsJumpLink,
        clsIllegal
    } instrClassT;

    typedef enum logic [2:0] {
        phReset,
        phFetch,
        phDecode,
        phExecute,
        phTrap
    } phaseT;

    // endRetire also marks the normal last cycle of reset, fetch, decode and trap
    typedef enum logic [1:0] {
        endNone,
        endRetire,
        endBranch,
        endTrap
    } endingT;

    typedef logic [2:0] aluOpT;
    localparam aluOpT AluPass = 3'd0;
    localparam aluOpT AluAdd  = 3'd1;
    localparam aluOpT AluSub  = 3'd2;
    localparam aluOpT AluAnd  = 3'd3;

    typedef logic [2:0] shiftOpT;
    localparam shiftOpT ShiftIdle       = 3'd0;
    localparam shiftOpT ShiftLoad       = 3'd1;
    localparam shiftOpT ShiftLeft       = 3'd2;
    localparam shiftOpT ShiftRightLog   = 3'd3;
    localparam shiftOpT ShiftRightArith = 3'd4;

    typedef logic [1:0] pcSourceT;
    localparam pcSourceT PcAlu    = 2'd0;
    localparam pcSourceT PcBranch = 2'd1;
    localparam pcSourceT PcJump   = 2'd2;
    localparam pcSourceT PcVector = 2'd3;

    typedef logic [2:0] regDataT;
    localparam regDataT DataAlu   = 3'd0;
    localparam regDataT DataMem   = 3'd1;
    localparam regDataT DataShift = 3'd2;
    localparam regDataT DataStack = 3'd3;

    typedef logic [1:0] regDstT;
    localparam regDstT DstRt = 2'd0;
    localparam regDstT DstRd = 2'd1;
    localparam regDstT DstRa = 2'd2;
    localparam regDstT DstSp = 2'd3;

    // ALU operand selects
    typedef logic [1:0] aluSrcT;
    localparam aluSrcT SrcAPc     = 2'd0;
    localparam aluSrcT SrcAReg    = 2'd1;
    localparam aluSrcT SrcBReg    = 2'd0;
    localparam aluSrcT SrcBFour   = 2'd1;
    localparam aluSrcT SrcBImm    = 2'd2;
    localparam aluSrcT SrcBBranch = 2'd3;

    typedef struct packed {
        logic overflow;
        logic eq;
        logic gt;
    } aluFlagsT;

    typedef struct packed {
        logic     pcWrite;
        pcSourceT pcSource;
        logic     iorData;
        logic     irWrite;
        logic     memWrite;
        logic     regWrite;
        regDstT   regDst;
        regDataT  regData;
        aluSrcT   aluSrcA;
        aluSrcT   aluSrcB;
        aluOpT    aluOp;
        logic     aluOutWrite;
        logic     aWrite;
        logic     bWrite;
        logic     signExtend;
        shiftOpT  shiftOp;
        logic     shiftAmtImm;
        logic     epcWrite;
    } datapathCtrlT;

    // stack pointer init held while in reset
    localparam datapathCtrlT StackWord = '{
        regWrite: 1'b1,
        regDst: DstSp,
        regData: DataStack,
        default: '0
    };

endpackage

// ==== logic/controlUnit.sv ====
module controlUnit #(
    parameter int FetchSteps = 3
) (
    input  logic                     clk,
    input  logic                     reset,
    input  controlPkg::opcodeT       opcode,
    input  controlPkg::functT        funct,
    input  controlPkg::aluFlagsT     flags,
    output controlPkg::datapathCtrlT ctrl,
    output logic                     resetOut
);

    controlPkg::instrClassT instrClass;
    controlPkg::phaseT      phase;
    controlPkg::stepT       step;
    controlPkg::endingT     ending;

    instrDecoder decoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    phaseSequencer #(
        .FetchSteps (FetchSteps)
    ) sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .funct      (funct),
        .flags      (flags),
        .phase      (phase),
        .step       (step),
        .ending     (ending)
    );

    controlWordGen wordGen (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .step       (step),
        .instrClass (instrClass),
        .funct      (funct),
        .ending     (ending),
        .ctrl       (ctrl),
        .resetOut   (resetOut)
    );

endmodule

// ==== logic/controlWordGen.sv ====
module controlWordGen (
    input  logic                     clk,
    input  logic                     reset,
    input  controlPkg::phaseT        phase,
    input  controlPkg::stepT         step,
    input  controlPkg::instrClassT   instrClass,
    input  controlPkg::functT        funct,
    input  controlPkg::endingT       ending,
    output controlPkg::datapathCtrlT ctrl,
    output logic                     resetOut
);

    controlPkg::datapathCtrlT word;
    controlPkg::regDstT       classDst;
    controlPkg::regDataT      classData;
    logic                     classWrites;
    logic                     isImm;
    logic                     isBranch;

    assign isImm    = instrClass == controlPkg::clsAddi;
    assign isBranch = instrClass == controlPkg::clsBranchEq ||
                      instrClass == controlPkg::clsBranchNe;

    // destination and data source of the register-writing classes
    always_comb begin
        classWrites = 1'b1;
        classDst    = controlPkg::DstRt;
        classData   = controlPkg::DataAlu;
        case (instrClass)
            controlPkg::clsAluReg: classDst = controlPkg::DstRd;
            controlPkg::clsShift: begin
                classDst  = controlPkg::DstRd;
                classData = controlPkg::DataShift;
            end
            controlPkg::clsAddi: classDst = controlPkg::DstRt;
            controlPkg::clsLoad: classData = controlPkg::DataMem;
            controlPkg::clsJumpLink: classDst = controlPkg::DstRa;
            default: classWrites = 1'b0;
        endcase
    end

    always_comb begin
        word = '0;
        case (phase)
            controlPkg::phFetch: begin
                // pc + 4 each cycle, committed with the instruction
                word.aluSrcA = controlPkg::SrcAPc;
                word.aluSrcB = controlPkg::SrcBFour;
                word.aluOp   = controlPkg::AluAdd;
                if (ending != controlPkg::endNone) begin
                    word.pcWrite  = 1'b1;
                    word.irWrite  = 1'b1;
                    word.pcSource = controlPkg::PcAlu;
                end
            end
            controlPkg::phDecode: begin
                // read operands, branch target into aluOut
                word.aWrite      = 1'b1;
                word.bWrite      = 1'b1;
                word.signExtend  = 1'b1;
                word.aluOutWrite = 1'b1;
                word.aluSrcA     = controlPkg::SrcAPc;
                word.aluSrcB     = controlPkg::SrcBBranch;
                word.aluOp       = controlPkg::AluAdd;
            end
            controlPkg::phExecute: begin
                case (instrClass)
                    controlPkg::clsAluReg, controlPkg::clsAddi: begin
                        word.aluSrcA     = controlPkg::SrcAReg;
                        word.aluSrcB     = isImm ? controlPkg::SrcBImm : controlPkg::SrcBReg;
                        word.signExtend  = isImm;
                        word.aluOutWrite = step == 3'd0;
                        if (isImm || funct == controlPkg::FnAdd) begin
                            word.aluOp = controlPkg::AluAdd;
                        end else if (funct == controlPkg::FnSub) begin
                            word.aluOp = controlPkg::AluSub;
                        end else begin
                            word.aluOp = controlPkg::AluAnd;
                        end
                    end
                    controlPkg::clsShift: begin
                        word.shiftAmtImm = 1'b1;
                        case (step)
                            3'd0, 3'd1: word.shiftOp = controlPkg::ShiftLoad;
                            3'd2: begin
                                if (funct == controlPkg::FnSll) begin
                                    word.shiftOp = controlPkg::ShiftLeft;
                                end else if (funct == controlPkg::FnSrl) begin
                                    word.shiftOp = controlPkg::ShiftRightLog;
                                end else begin
                                    word.shiftOp = controlPkg::ShiftRightArith;
                                end
                            end
                            default: word.shiftOp = controlPkg::ShiftIdle;
                        endcase
                    end
                    controlPkg::clsLoad, controlPkg::clsStore: begin
                        // address first, then memory sees aluOut
                        word.aluSrcA     = controlPkg::SrcAReg;
                        word.aluSrcB     = controlPkg::SrcBImm;
                        word.aluOp       = controlPkg::AluAdd;
                        word.signExtend  = 1'b1;
                        word.aluOutWrite = step == 3'd0;
                        word.iorData     = step != 3'd0;
                    end
                    controlPkg::clsBranchEq, controlPkg::clsBranchNe: begin
                        // compare only, aluOut keeps the target
                        word.aluSrcA = controlPkg::SrcAReg;
                        word.aluSrcB = controlPkg::SrcBReg;
                        word.aluOp   = controlPkg::AluSub;
                    end
                    controlPkg::clsJumpLink: begin
                        // return address saved in aluOut
                        word.aluSrcA     = controlPkg::SrcAPc;
                        word.aluOp       = controlPkg::AluPass;
                        word.aluOutWrite = step == 3'd0;
                    end
                    default: ;
                endcase
                case (ending)
                    controlPkg::endRetire: begin
                        word.regWrite = classWrites;
                        word.regDst   = classDst;
                        word.regData  = classData;
                        word.memWrite = instrClass == controlPkg::clsStore;
                    end
                    controlPkg::endBranch: begin
                        word.pcWrite  = 1'b1;
                        word.pcSource = isBranch ? controlPkg::PcBranch : controlPkg::PcJump;
                        word.regWrite = instrClass == controlPkg::clsJumpLink;
                        word.regDst   = classDst;
                        word.regData  = classData;
                    end
                    default: ;
                endcase
            end
            controlPkg::phTrap: begin
                word.epcWrite = 1'b1;
                word.pcWrite  = 1'b1;
                word.pcSource = controlPkg::PcVector;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl     <= controlPkg::StackWord;
            resetOut <= 1'b1;
        end else begin
            ctrl     <= word;
            resetOut <= 1'b0;
        end
    end

endmodule

// ==== logic/instrDecoder.sv ====
module instrDecoder (
    input  controlPkg::opcodeT     opcode,
    input  controlPkg::functT      funct,
    output controlPkg::instrClassT instrClass
);

    always_comb begin
        case (opcode)
            controlPkg::OpRType: begin
                case (funct)
                    controlPkg::FnAdd,
                    controlPkg::FnSub,
                    controlPkg::FnAnd: instrClass = controlPkg::clsAluReg;
                    controlPkg::FnSll,
                    controlPkg::FnSrl,
                    controlPkg::FnSra: instrClass = controlPkg::clsShift;
                    // variable shifts, mult/div and friends are not supported
                    default: instrClass = controlPkg::clsIllegal;
                endcase
            end
            controlPkg::OpAddi: instrClass = controlPkg::clsAddi;
            controlPkg::OpLw:   instrClass = controlPkg::clsLoad;
            controlPkg::OpSw:   instrClass = controlPkg::clsStore;
            controlPkg::OpBeq:  instrClass = controlPkg::clsBranchEq;
            controlPkg::OpBne:  instrClass = controlPkg::clsBranchNe;
            controlPkg::OpJ:    instrClass = controlPkg::clsJump;
            controlPkg::OpJal:  instrClass = controlPkg::clsJumpLink;
            default:            instrClass = controlPkg::clsIllegal;
        endcase
    end

endmodule

// ==== logic/phaseSequencer.sv ====
module phaseSequencer #(
    parameter int FetchSteps = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  controlPkg::instrClassT instrClass,
    input  controlPkg::functT      funct,
    input  controlPkg::aluFlagsT   flags,
    output controlPkg::phaseT      phase,
    output controlPkg::stepT       step,
    output controlPkg::endingT     ending
);

    localparam controlPkg::stepT FetchLast  = controlPkg::stepT'(FetchSteps - 1);
    localparam controlPkg::stepT DecodeLast = 3'd1;

    controlPkg::stepT execLast;
    logic             overflowTrap;
    logic             taken;

    // last execute step of each class
    always_comb begin
        case (instrClass)
            controlPkg::clsShift,
            controlPkg::clsLoad,
            controlPkg::clsStore:    execLast = 3'd3;
            controlPkg::clsAluReg,
            controlPkg::clsAddi,
            controlPkg::clsBranchEq,
            controlPkg::clsBranchNe,
            controlPkg::clsJumpLink: execLast = 3'd1;
            default:                 execLast = 3'd0;
        endcase
    end

    // only signed add and sub trap, AND never does
    assign overflowTrap = flags.overflow &&
        (instrClass == controlPkg::clsAddi ||
         (instrClass == controlPkg::clsAluReg &&
          (funct == controlPkg::FnAdd || funct == controlPkg::FnSub)));

    assign taken = instrClass == controlPkg::clsJump ||
        instrClass == controlPkg::clsJumpLink ||
        (instrClass == controlPkg::clsBranchEq && flags.eq) ||
        (instrClass == controlPkg::clsBranchNe && !flags.eq);

    always_comb begin
        ending = controlPkg::endNone;
        case (phase)
            controlPkg::phFetch: begin
                if (step == FetchLast) begin
                    ending = controlPkg::endRetire;
                end
            end
            controlPkg::phDecode: begin
                if (step == DecodeLast) begin
                    ending = controlPkg::endRetire;
                end
            end
            controlPkg::phExecute: begin
                if (step == execLast) begin
                    if (overflowTrap) begin
                        ending = controlPkg::endTrap;
                    end else if (taken) begin
                        ending = controlPkg::endBranch;
                    end else begin
                        ending = controlPkg::endRetire;
                    end
                end
            end
            // reset and trap both last a single cycle
            default: ending = controlPkg::endRetire;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= controlPkg::phReset;
            step  <= '0;
        end else if (ending == controlPkg::endNone) begin
            step <= step + 3'd1;
        end else begin
            step <= '0;
            case (phase)
                controlPkg::phReset:  phase <= controlPkg::phFetch;
                controlPkg::phFetch:  phase <= controlPkg::phDecode;
                controlPkg::phDecode: phase <= controlPkg::phExecute;
                controlPkg::phExecute: begin
                    if (ending == controlPkg::endTrap) begin
                        phase <= controlPkg::phTrap;
                    end else begin
                        phase <= controlPkg::phFetch;
                    end
                end
                default: phase <= controlPkg::phFetch;
            endcase
        end
    end

endmodule

// ==== sim/controlStimulus.txt ====
// opcode_funct_flags(ov eq gt)_execLen_writes(reg mem pc trap), all hex
// flag bits the instruction ignores are replaced with random values
00_20_0_2_8
00_20_4_2_1
00_22_0_2_8
00_22_4_2_1
00_24_4_2_8
00_00_0_4_8
00_02_0_4_8
00_03_0_4_8
08_00_0_2_8
08_00_4_2_1
23_00_0_4_8
2b_00_0_4_4
04_00_2_2_2
04_00_0_2_0
05_00_0_2_2
05_00_2_2_0
02_00_0_1_2
03_00_0_2_a
3f_00_0_1_0
00_18_0_1_0

// ==== sim/controlUnitTb.sv ====
module controlUnitTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FetchSteps = 3;
    localparam int MaxLines   = 64;

    logic                     clk = 1'b0;
    logic                     reset;
    controlPkg::opcodeT       opcode;
    controlPkg::functT        funct;
    controlPkg::aluFlagsT     flags;
    controlPkg::datapathCtrlT ctrl;
    logic                     resetOut;

    // opcode byte, funct byte, flags, execute length, writes {reg, mem, pc, trap}
    logic [27:0] stim [0:MaxLines-1];
    int          lineCount;
    int          errors;
    logic        loaded = 1'b0;
    logic [31:0] rngState;

    controlUnit #(
        .FetchSteps (FetchSteps)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .flags    (flags),
        .ctrl     (ctrl),
        .resetOut (resetOut)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic reportMismatch(input string msg);
        errors++;
        $display("Mismatch at %0d ns: %s", $time, msg);
    endtask

    task automatic checkResetWord();
        controlPkg::datapathCtrlT stackExp;
        stackExp          = '0;
        stackExp.regWrite = 1'b1;
        stackExp.regDst   = controlPkg::DstSp;
        stackExp.regData  = controlPkg::DataStack;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (ctrl !== stackExp || resetOut !== 1'b1) begin
            reportMismatch($sformatf("in reset ctrl %h resetOut %b, expected %h and 1",
                ctrl, resetOut, stackExp));
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (resetOut !== 1'b0 || ctrl.pcWrite || ctrl.irWrite || ctrl.memWrite ||
                ctrl.regWrite || ctrl.epcWrite) begin
            reportMismatch($sformatf("after reset ctrl %h resetOut %b, expected no strobes",
                ctrl, resetOut));
        end
    endtask

    // drive one instruction, then watch its words up to the next irWrite
    task automatic runInstruction(input logic [27:0] line);
        controlPkg::opcodeT   op;
        controlPkg::functT    fn;
        controlPkg::regDstT   expDst;
        controlPkg::regDataT  expData;
        controlPkg::pcSourceT expSrc;
        logic [2:0]           mask;
        logic [3:0]           seen;
        int                   cycles;
        int                   period;
        op      = line[25:20];
        fn      = line[17:12];
        expDst  = controlPkg::DstRt;
        expData = controlPkg::DataAlu;
        expSrc  = controlPkg::PcBranch;
        // overflow for the ALU ops, eq only for branches
        mask[2] = op == controlPkg::OpAddi ||
            (op == controlPkg::OpRType &&
             (fn == controlPkg::FnAdd || fn == controlPkg::FnSub || fn == controlPkg::FnAnd));
        mask[1] = op == controlPkg::OpBeq || op == controlPkg::OpBne;
        mask[0] = 1'b0;
        case (op)
            controlPkg::OpRType: begin
                expDst = controlPkg::DstRd;
                if (fn inside {controlPkg::FnSll, controlPkg::FnSrl, controlPkg::FnSra}) begin
                    expData = controlPkg::DataShift;
                end
            end
            controlPkg::OpLw: expData = controlPkg::DataMem;
            controlPkg::OpJ:  expSrc = controlPkg::PcJump;
            controlPkg::OpJal: begin
                expDst = controlPkg::DstRa;
                expSrc = controlPkg::PcJump;
            end
            default: ;
        endcase
        period   = FetchSteps + 2 + int'(line[7:4]) + int'(line[0]);
        rngState = xorshift(rngState);
        @(posedge clk);
        opcode <= op;
        funct  <= fn;
        flags  <= (line[10:8] & mask) | (rngState[2:0] & ~mask);
        seen   = '0;
        cycles = 0;
        forever begin
            @(negedge clk);
            cycles++;
            if (ctrl.irWrite) begin
                break;
            end
            if (ctrl.regWrite && (ctrl.regDst !== expDst || ctrl.regData !== expData)) begin
                reportMismatch($sformatf("opcode %h funct %h writes reg %0d from %0d",
                    op, fn, ctrl.regDst, ctrl.regData));
            end
            if (ctrl.pcWrite && !ctrl.epcWrite && ctrl.pcSource !== expSrc) begin
                reportMismatch($sformatf("opcode %h pc source %0d, expected %0d",
                    op, ctrl.pcSource, expSrc));
            end
            seen |= {ctrl.regWrite, ctrl.memWrite, ctrl.pcWrite && !ctrl.epcWrite,
                ctrl.epcWrite};
        end
        if (cycles != period) begin
            reportMismatch($sformatf("opcode %h funct %h period %0d cycles, expected %0d",
                op, fn, cycles, period));
        end
        if (seen !== line[3:0]) begin
            reportMismatch($sformatf("opcode %h funct %h writes %b, expected %b",
                op, fn, seen, line[3:0]));
        end
    endtask

    initial begin
        reset    = 1'b1;
        opcode   = '0;
        funct    = '0;
        flags    = '0;
        errors   = 0;
        rngState = 32'h71ac_8fb1;
        for (int i = 0; i < MaxLines; i++) begin
            stim[i] = '1;
        end
        $readmemh("sim/controlStimulus.txt", stim);
        lineCount = 0;
        while (lineCount < MaxLines && stim[lineCount] !== '1) begin
            lineCount++;
        end
        loaded = 1'b1;
        checkResetWord();
        if (lineCount == 0) begin
            errors++;
            $display("No stimulus lines could be read from sim/controlStimulus.txt");
        end else begin
            do @(negedge clk); while (!ctrl.irWrite);
            for (int i = 0; i < lineCount; i++) begin
                runInstruction(stim[i]);
            end
        end
        $display("instructions %0d, errors %0d", lineCount, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // at most 12 cycles per instruction, plus reset and some slack
    initial begin
        wait (loaded);
        #((lineCount * 12 + 10) * 20 + 1000);
        $display("Timeout: the instructions did not finish in time");
        $display("instructions %0d, errors %0d", lineCount, errors + 1);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== sim/controlUnit_checker.sv ====
module controlUnit_checker (
    input logic                     clk,
    input logic                     reset,
    input controlPkg::datapathCtrlT ctrl,
    input logic                     resetOut
);

    timeunit 1ns;
    timeprecision 100ps;

    // a cycle loads a register or stores, never both
    writeExclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.memWrite && ctrl.regWrite))
        else $error("memWrite and regWrite set in the same cycle");

    fetchCommit: assert property (@(posedge clk) disable iff (reset)
        ctrl.irWrite |-> ctrl.pcWrite)
        else $error("irWrite without pcWrite");

    resetRelease: assert property (@(posedge clk) $fell(reset) |=> !resetOut)
        else $error("resetOut still high one cycle after reset fell");

    epcVector: assert property (@(posedge clk) disable iff (reset)
        ctrl.epcWrite |-> ctrl.pcSource == controlPkg::PcVector)
        else $error("epcWrite with a pc source other than the exception vector");

endmodule

bind controlUnit controlUnit_checker checks (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .resetOut (resetOut)
);
